// ==== src/logCfgPkg.sv ====
////////////////////////////////////////////////////////////////////////////
// sizes shared by the trace unit; fifoDepth must equal 2**fifoPtrWidth
// counters are countWidth wide and saturate at all ones
////////////////////////////////////////////////////////////////////////////

package logCfgPkg;

  ////////////////////////////////////////////////////////////////////////////
  // record payload
  ////////////////////////////////////////////////////////////////////////////

  // address and pc bits kept per record, upper bits are dropped
  localparam int addrWidth = 24;

  ////////////////////////////////////////////////////////////////////////////
  // buffering
  ////////////////////////////////////////////////////////////////////////////

  // entries in the record buffer
  localparam int fifoDepth = 8;

  // pointer width, wraps naturally with a power-of-two depth
  localparam int fifoPtrWidth = 3;

  ////////////////////////////////////////////////////////////////////////////
  // statistics
  ////////////////////////////////////////////////////////////////////////////

  // drop, arbitration and miss counters
  localparam int countWidth = 8;

endpackage

// ==== src/traceFmtPkg.sv ====
////////////////////////////////////////////////////////////////////////////
// trace word layout; every record is one 32-bit word
// marker and access views share the kind field in the top two bits
////////////////////////////////////////////////////////////////////////////

package traceFmtPkg;
  import logCfgPkg::*;

  typedef enum logic [1:0] {
    kindMarker = 2'd0,
    kindICache = 2'd1,
    kindDCache = 2'd2,
    kindBranch = 2'd3
  } recKind;

  typedef enum logic [3:0] {
    mkTrain   = 4'h0,
    mkBegin   = 4'h1,
    mkEnd     = 4'h2,
    mkInval   = 4'h3,
    mkSummary = 4'h4
  } markerCode;

  typedef enum logic [1:0] {
    accRead   = 2'd0,
    accWrite  = 2'd1,
    accAtomic = 2'd2,
    accFlush  = 2'd3
  } accType;

  typedef enum logic [1:0] {
    outHit   = 2'd0,
    outMiss  = 2'd1,
    outEvict = 2'd2,
    outDirty = 2'd3
  } outcome;

  ////////////////////////////////////////////////////////////////////////////
  // input bundles from the core
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                 valid;
    logic                 cacheable;
    logic [addrWidth-1:0] addr;
    outcome               aOut;
  } iAccessT;

  typedef struct packed {
    logic                 valid;
    logic                 cacheable;
    logic [addrWidth-1:0] addr;
    accType               aType;
    outcome               aOut;
  } dAccessT;

  typedef struct packed {
    logic                 valid;
    logic [addrWidth-1:0] pc;
    logic                 taken;
  } branchT;

  ////////////////////////////////////////////////////////////////////////////
  // trace word views
  ////////////////////////////////////////////////////////////////////////////

  // branch records put taken in aOut[0]
  typedef struct packed {
    recKind               kind;
    logic [addrWidth-1:0] addr;
    accType               aType;
    outcome               aOut;
    logic [1:0]           spare;
  } accessViewT;

  typedef struct packed {
    recKind                kind;
    markerCode             code;
    logic [17:0]           pad;
    logic [countWidth-1:0] count;
  } markerViewT;

  typedef union packed {
    accessViewT acc;
    markerViewT mk;
  } traceRecord;

  function automatic traceRecord makeMarker(markerCode code, logic [countWidth-1:0] count);
    traceRecord w;
    w = '0;
    w.mk.kind  = kindMarker;
    w.mk.code  = code;
    w.mk.count = count;
    return w;
  endfunction

  function automatic traceRecord makeAccess(recKind kind, logic [addrWidth-1:0] addr,
                                            accType aType, outcome aOut);
    traceRecord w;
    w = '0;
    w.acc.kind  = kind;
    w.acc.addr  = addr;
    w.acc.aType = aType;
    w.acc.aOut  = aOut;
    return w;
  endfunction

endpackage

// ==== src/eventCapture.sv ====
////////////////////////////////////////////////////////////////////////////
// one record per cycle; lower priority candidates are counted, not queued
// marker inputs are levels, only their rising edges produce records
////////////////////////////////////////////////////////////////////////////

module eventCapture import logCfgPkg::*, traceFmtPkg::*; (
  input  logic                  clk,
  input  logic                  resetEdge,
  input  iAccessT               iAcc,
  input  dAccessT               dAcc,
  input  branchT                br,
  input  logic                  sampleStart,
  input  logic                  flushStart,
  input  logic                  flushDone,
  input  logic                  iInval,
  output traceRecord            recOut,
  output logic                  recValid,
  output logic [countWidth-1:0] arbLost
);

  logic resetD;
  logic sampleD;
  logic endD;
  logic invalD;
  logic endTerm;

  logic trainC;
  logic beginC;
  logic endC;
  logic invalC;
  logic dCacheC;
  logic iCacheC;
  logic branchC;
  logic anyCand;

  logic [2:0]            numCand;
  logic [2:0]            lostNow;
  logic [countWidth:0]   lostSum;
  traceRecord            nextRec;

  ////////////////////////////////////////////////////////////////////////////
  // edge detection
  ////////////////////////////////////////////////////////////////////////////

  // reset level one cycle back, high only in the TRAIN cycle while reset is low
  always_ff @(posedge clk) begin
    resetD <= resetEdge;
  end

  always_ff @(posedge clk) begin
    if (resetEdge) begin
      sampleD <= 1'b0;
      endD    <= 1'b0;
      invalD  <= 1'b0;
    end else begin
      sampleD <= sampleStart;
      endD    <= endTerm;
      invalD  <= iInval;
    end
  end

  // end of run is a flush that has started and not finished
  assign endTerm = flushStart & ~flushDone;

  assign trainC  = resetD & ~resetEdge;
  assign beginC  = sampleStart & ~sampleD;
  assign endC    = endTerm & ~endD;
  assign invalC  = iInval & ~invalD;

  // flushes are logged even for non-cacheable regions
  assign dCacheC = dAcc.valid & (dAcc.cacheable | (dAcc.aType == accFlush));
  assign iCacheC = iAcc.valid & iAcc.cacheable;
  assign branchC = br.valid;

  assign anyCand = trainC | endC | beginC | invalC | dCacheC | iCacheC | branchC;

  ////////////////////////////////////////////////////////////////////////////
  // fixed priority pick
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    nextRec = '0;
    if (trainC) begin
      nextRec = makeMarker(mkTrain, '0);
    end else if (endC) begin
      nextRec = makeMarker(mkEnd, '0);
    end else if (beginC) begin
      nextRec = makeMarker(mkBegin, '0);
    end else if (invalC) begin
      nextRec = makeMarker(mkInval, '0);
    end else if (dCacheC) begin
      nextRec = makeAccess(kindDCache, dAcc.addr, dAcc.aType, dAcc.aOut);
    end else if (iCacheC) begin
      nextRec = makeAccess(kindICache, iAcc.addr, accRead, iAcc.aOut);
    end else if (branchC) begin
      nextRec = makeAccess(kindBranch, br.pc, accRead, outcome'({1'b0, br.taken}));
    end
  end

  // every candidate beyond the winner is a loss
  assign numCand = 3'(trainC) + 3'(endC) + 3'(beginC) + 3'(invalC) +
                   3'(dCacheC) + 3'(iCacheC) + 3'(branchC);
  assign lostNow = anyCand ? numCand - 3'd1 : 3'd0;
  assign lostSum = {1'b0, arbLost} + (countWidth + 1)'(lostNow);

  always_ff @(posedge clk) begin
    if (resetEdge) begin
      recValid <= 1'b0;
      arbLost  <= '0;
    end else begin
      recValid <= anyCand;
      // saturate rather than wrap
      if (lostSum[countWidth]) begin
        arbLost <= '1;
      end else begin
        arbLost <= lostSum[countWidth-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    recOut <= nextRec;
  end

endmodule

// ==== src/traceFifo.sv ====
////////////////////////////////////////////////////////////////////////////
// no backpressure; a write to a full buffer is lost and counted
// rdData shows the oldest entry and is only meaningful while not empty
////////////////////////////////////////////////////////////////////////////

module traceFifo import logCfgPkg::*, traceFmtPkg::*; (
  input  logic                  clk,
  input  logic                  resetEdge,
  input  traceRecord            wrData,
  input  logic                  wrEn,
  input  logic                  pop,
  output traceRecord            rdData,
  output logic                  empty,
  output logic [countWidth-1:0] overflowCnt
);

  traceRecord              mem [fifoDepth];
  logic [fifoPtrWidth-1:0] wrPtr;
  logic [fifoPtrWidth-1:0] rdPtr;
  logic [fifoPtrWidth:0]   occ;
  logic                    full;
  logic                    doWrite;
  logic                    doRead;

  assign full    = (occ == (fifoPtrWidth + 1)'(fifoDepth));
  assign empty   = (occ == '0);
  assign doWrite = wrEn & ~full;
  assign doRead  = pop & ~empty;
  assign rdData  = mem[rdPtr];

  always_ff @(posedge clk) begin
    if (doWrite) begin
      mem[wrPtr] <= wrData;
    end
  end

  always_ff @(posedge clk) begin
    if (resetEdge) begin
      wrPtr       <= '0;
      rdPtr       <= '0;
      occ         <= '0;
      overflowCnt <= '0;
    end else begin
      if (doWrite) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doRead) begin
        rdPtr <= rdPtr + 1'b1;
      end
      // occupancy only moves when exactly one side is active
      if (doWrite && !doRead) begin
        occ <= occ + 1'b1;
      end else if (doRead && !doWrite) begin
        occ <= occ - 1'b1;
      end
      if (wrEn && full && (overflowCnt != '1)) begin
        overflowCnt <= overflowCnt + 1'b1;
      end
    end
  end

endmodule

// ==== src/traceEmitter.sv ====
////////////////////////////////////////////////////////////////////////////
// pops while holdOff is low; a summary word always follows an emitted END
// miss count covers cache records emitted between BEGIN and END only
////////////////////////////////////////////////////////////////////////////

module traceEmitter import logCfgPkg::*, traceFmtPkg::*; (
  input  logic       clk,
  input  logic       resetEdge,
  input  traceRecord rdData,
  input  logic       empty,
  input  logic       holdOff,
  output logic       pop,
  output traceRecord wordOut,
  output logic       wordValid
);

  logic                  sampling;
  logic [countWidth-1:0] missCnt;
  logic                  isMarker;
  logic                  beginOut;
  logic                  endOut;
  logic                  missOut;

  ////////////////////////////////////////////////////////////////////////////
  // decode of the word currently on the output
  ////////////////////////////////////////////////////////////////////////////

  assign isMarker = wordValid && (wordOut.mk.kind == kindMarker);
  assign beginOut = isMarker && (wordOut.mk.code == mkBegin);
  assign endOut   = isMarker && (wordOut.mk.code == mkEnd);

  // evictions and dirty evictions count as misses too
  assign missOut  = wordValid &&
                    ((wordOut.acc.kind == kindICache) || (wordOut.acc.kind == kindDCache)) &&
                    (wordOut.acc.aOut != outHit);

  // the summary slot takes the cycle after END, so no pop then
  assign pop = ~empty & ~holdOff & ~endOut;

  always_ff @(posedge clk) begin
    if (resetEdge) begin
      wordValid <= 1'b0;
      sampling  <= 1'b0;
      missCnt   <= '0;
    end else begin
      wordValid <= pop | endOut;
      if (endOut) begin
        sampling <= 1'b0;
        missCnt  <= '0;
      end else begin
        if (beginOut) begin
          sampling <= 1'b1;
        end
        if (sampling && missOut && (missCnt != '1)) begin
          missCnt <= missCnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (endOut) begin
      wordOut <= makeMarker(mkSummary, missCnt);
    end else if (pop) begin
      wordOut <= rdData;
    end
  end

endmodule

// ==== src/traceLogger.sv ====
////////////////////////////////////////////////////////////////////////////
// event trace unit beside the core, three cycles from event to wordValid
// records are dropped, never stalled, when the buffer overflows
////////////////////////////////////////////////////////////////////////////

module traceLogger import logCfgPkg::*, traceFmtPkg::*; (
  input  logic                  clk,
  input  logic                  resetEdge,
  input  iAccessT               iAcc,
  input  dAccessT               dAcc,
  input  branchT                br,
  input  logic                  sampleStart,
  input  logic                  flushStart,
  input  logic                  flushDone,
  input  logic                  iInval,
  input  logic                  holdOff,
  output traceRecord            wordOut,
  output logic                  wordValid,
  output logic [countWidth-1:0] arbLost,
  output logic [countWidth-1:0] overflowCnt
);

  traceRecord recOut;
  logic       recValid;
  traceRecord fifoData;
  logic       fifoEmpty;
  logic       pop;

  // producer
  eventCapture capture0 (
    .clk         (clk),
    .resetEdge   (resetEdge),
    .iAcc        (iAcc),
    .dAcc        (dAcc),
    .br          (br),
    .sampleStart (sampleStart),
    .flushStart  (flushStart),
    .flushDone   (flushDone),
    .iInval      (iInval),
    .recOut      (recOut),
    .recValid    (recValid),
    .arbLost     (arbLost)
  );

  traceFifo fifo0 (
    .clk         (clk),
    .resetEdge   (resetEdge),
    .wrData      (recOut),
    .wrEn        (recValid),
    .pop         (pop),
    .rdData      (fifoData),
    .empty       (fifoEmpty),
    .overflowCnt (overflowCnt)
  );

  // consumer
  traceEmitter emitter0 (
    .clk       (clk),
    .resetEdge (resetEdge),
    .rdData    (fifoData),
    .empty     (fifoEmpty),
    .holdOff   (holdOff),
    .pop       (pop),
    .wordOut   (wordOut),
    .wordValid (wordValid)
  );

endmodule

// ==== dv/traceLoggerTb.sv ====
////////////////////////////////////////////////////////////////////////////
// replays dv/traceLoggerPatterns.txt, so run it from the project root
// expected words are built here from the field layout of the trace word
////////////////////////////////////////////////////////////////////////////

module traceLoggerTb import logCfgPkg::*, traceFmtPkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int resetCycles = 16;
  localparam int stimFields  = 17;
  localparam int drainLimit  = 200;

  logic                  clk;
  logic                  resetEdge;
  iAccessT               iAcc;
  dAccessT               dAcc;
  branchT                br;
  logic                  sampleStart;
  logic                  flushStart;
  logic                  flushDone;
  logic                  iInval;
  logic                  holdOff;
  traceRecord            wordOut;
  logic                  wordValid;
  logic [countWidth-1:0] arbLost;
  logic [countWidth-1:0] overflowCnt;

  // words still to come out, in order
  logic [31:0] expWords [$];

  traceLogger dut0 (
    .clk         (clk),
    .resetEdge   (resetEdge),
    .iAcc        (iAcc),
    .dAcc        (dAcc),
    .br          (br),
    .sampleStart (sampleStart),
    .flushStart  (flushStart),
    .flushDone   (flushDone),
    .iInval      (iInval),
    .holdOff     (holdOff),
    .wordOut     (wordOut),
    .wordValid   (wordValid),
    .arbLost     (arbLost),
    .overflowCnt (overflowCnt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // expected word layout
  ////////////////////////////////////////////////////////////////////////////

  // kind, addr, type, outcome, two spare bits at the bottom
  function automatic logic [31:0] accessWord(logic [1:0] kind, logic [addrWidth-1:0] addr,
                                             logic [1:0] aType, logic [1:0] aOut);
    return {kind, addr, aType, aOut, 2'b00};
  endfunction

  // marker kind is zero, count sits in the low byte
  function automatic logic [31:0] markerWord(logic [3:0] code, logic [countWidth-1:0] count);
    return {2'b00, code, 18'd0, count};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // checking
  ////////////////////////////////////////////////////////////////////////////

  task automatic failRun(string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      failRun($sformatf("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  // wordOut is registered on the rising edge, so look at it on the falling one
  always @(negedge clk) begin
    if (!resetEdge && wordValid) begin
      if (expWords.size() == 0) begin
        failRun($sformatf("an extra trace word 0x%08h came out", 32'(wordOut)));
      end else begin
        checkValue("wordOut", 32'(wordOut), expWords.pop_front());
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  // levels keep their value, only the strobes drop
  task automatic driveIdle();
    @(posedge clk);
    iAcc.valid <= 1'b0;
    dAcc.valid <= 1'b0;
    br.valid   <= 1'b0;
  endtask

  task automatic waitForWords();
    int cycles;
    cycles = 0;
    while (expWords.size() != 0) begin
      if (cycles == drainLimit) begin
        failRun("timed out waiting for the expected trace words");
      end else begin
        driveIdle();
        cycles++;
      end
    end
    // a few quiet cycles so a stray word would still be caught
    repeat (4) driveIdle();
  endtask

  task automatic applyStimulus(string args, int lineNo);
    logic [31:0] fld [stimFields];
    int          n;
    int unsigned gap;
    iAccessT     iNext;
    dAccessT     dNext;
    branchT      bNext;
    n = $sscanf(args, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7], fld[8],
                fld[9], fld[10], fld[11], fld[12], fld[13], fld[14], fld[15], fld[16]);
    if (n != stimFields) begin
      failRun($sformatf("line %0d has %0d stimulus fields instead of 17", lineNo, n));
    end
    iNext.valid     = fld[0][0];
    iNext.cacheable = fld[1][0];
    iNext.addr      = fld[2][addrWidth-1:0];
    iNext.aOut      = outcome'(fld[3][1:0]);
    dNext.valid     = fld[4][0];
    dNext.cacheable = fld[5][0];
    dNext.addr      = fld[6][addrWidth-1:0];
    dNext.aType     = accType'(fld[7][1:0]);
    dNext.aOut      = outcome'(fld[8][1:0]);
    bNext.valid     = fld[9][0];
    bNext.pc        = fld[10][addrWidth-1:0];
    bNext.taken     = fld[11][0];
    gap = $urandom_range(2, 0);
    repeat (gap) driveIdle();
    @(posedge clk);
    iAcc        <= iNext;
    dAcc        <= dNext;
    br          <= bNext;
    sampleStart <= fld[12][0];
    flushStart  <= fld[13][0];
    flushDone   <= fld[14][0];
    iInval      <= fld[15][0];
    holdOff     <= fld[16][0];
  endtask

  task automatic replayPatterns();
    int          fd;
    int          lineNo;
    string       line;
    string       rest;
    logic [7:0]  tag;
    logic [31:0] f0;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    lineNo = 0;
    fd = $fopen("dv/traceLoggerPatterns.txt", "r");
    if (fd == 0) begin
      failRun("could not open dv/traceLoggerPatterns.txt");
    end
    while ($fgets(line, fd) != 0) begin
      lineNo++;
      tag  = line.getc(0);
      rest = line.substr(1, line.len() - 1);
      case (tag)
        "S": applyStimulus(rest, lineNo);
        "A": begin
          if ($sscanf(rest, "%h %h %h %h", f0, f1, f2, f3) != 4) begin
            failRun($sformatf("line %0d: access line needs kind, addr, type, outcome", lineNo));
          end
          expWords.push_back(accessWord(f0[1:0], f1[addrWidth-1:0], f2[1:0], f3[1:0]));
        end
        "M": begin
          if ($sscanf(rest, "%h %h", f0, f1) != 2) begin
            failRun($sformatf("line %0d: marker line needs a code and a count", lineNo));
          end
          expWords.push_back(markerWord(f0[3:0], f1[countWidth-1:0]));
        end
        "C": begin
          if ($sscanf(rest, "%h %h", f0, f1) != 2) begin
            failRun($sformatf("line %0d: counter line needs two values", lineNo));
          end
          waitForWords();
          checkValue("arbLost", 32'(arbLost), f0);
          checkValue("overflowCnt", 32'(overflowCnt), f1);
        end
        "#", 8'h0a, 8'h0d, 8'h00: begin
        end
        default: failRun($sformatf("line %0d of the pattern file is not understood", lineNo));
      endcase
    end
    $fclose(fd);
  endtask

  initial begin
    void'($urandom(70044));
    resetEdge   = 1'b1;
    iAcc        = '0;
    dAcc        = '0;
    br          = '0;
    sampleStart = 1'b0;
    flushStart  = 1'b0;
    flushDone   = 1'b0;
    iInval      = 1'b0;
    holdOff     = 1'b0;
    repeat (resetCycles) @(posedge clk);
    resetEdge <= 1'b0;
    replayPatterns();
    if (expWords.size() != 0) begin
      failRun("the pattern file ended with trace words still expected");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

// ==== dv/traceLoggerPatterns.txt ====
# S iv ic iaddr io  dv dc daddr dt do  bv bpc bt  ss fs fd inv ho : one input cycle, hex
# A kind addr type out : expected access word    M code count : expected marker word
# C arbLost overflowCnt : wait until all words are out, then check the counters
# after reset: TRAIN marker, counters clear
M 0 0
C 0 0
# single accesses and branches, in order
S 1 1 000100 0 0 0 000000 0 0 0 000000 0 0 0 0 0 0
A 1 000100 0 0
S 0 0 000000 0 1 1 000200 1 1 0 000000 0 0 0 0 0 0
A 2 000200 1 1
S 0 0 000000 0 0 0 000000 0 0 1 000300 1 0 0 0 0 0
A 3 000300 0 1
# non-cacheable reads leave no word
S 1 0 000400 1 0 0 000000 0 0 0 000000 0 0 0 0 0 0
S 0 0 000000 0 1 0 000800 0 1 0 000000 0 0 0 0 0 0
# a non-cacheable flush is still logged
S 0 0 000000 0 1 0 000500 3 0 0 000000 0 0 0 0 0 0
A 2 000500 3 0
S 0 0 000000 0 1 1 000600 2 3 0 000000 0 0 0 0 0 0
A 2 000600 2 3
S 0 0 000000 0 0 0 000000 0 0 1 000700 0 0 0 0 0 0
A 3 000700 0 0
C 0 0
# invalidate edge with a data access and a branch in the same cycle
S 0 0 000000 0 1 1 000900 0 0 1 000a00 1 0 0 0 1 0
M 3 0
C 2 0
# twelve records under holdOff, eight fit
S 1 1 001000 0 0 0 000000 0 0 0 000000 0 0 0 0 0 1
S 1 1 001001 0 0 0 000000 0 0 0 000000 0 0 0 0 0 1
S 1 1 001002 0 0 0 000000 0 0 0 000000 0 0 0 0 0 1
S 1 1 001003 0 0 0 000000 0 0 0 000000 0 0 0 0 0 1
S 1 1 001004 0 0 0 000000 0 0 0 000000 0 0 0 0 0 1
S 1 1 001005 0 0 0 000000 0 0 0 000000 0 0 0 0 0 1
S 1 1 001006 0 0 0 000000 0 0 0 000000 0 0 0 0 0 1
S 1 1 001007 0 0 0 000000 0 0 0 000000 0 0 0 0 0 1
S 1 1 001008 0 0 0 000000 0 0 0 000000 0 0 0 0 0 1
S 1 1 001009 0 0 0 000000 0 0 0 000000 0 0 0 0 0 1
S 1 1 00100a 0 0 0 000000 0 0 0 000000 0 0 0 0 0 1
S 1 1 00100b 0 0 0 000000 0 0 0 000000 0 0 0 0 0 1
S 0 0 000000 0 0 0 000000 0 0 0 000000 0 0 0 0 0 0
A 1 001000 0 0
A 1 001001 0 0
A 1 001002 0 0
A 1 001003 0 0
A 1 001004 0 0
A 1 001005 0 0
A 1 001006 0 0
A 1 001007 0 0
C 2 4
# sampled region: three non-hits, two hits, then END and the summary
S 0 0 000000 0 0 0 000000 0 0 0 000000 0 1 0 0 0 0
M 1 0
S 0 0 000000 0 1 1 002000 0 1 0 000000 0 1 0 0 0 0
A 2 002000 0 1
S 1 1 002100 0 0 0 000000 0 0 0 000000 0 1 0 0 0 0
A 1 002100 0 0
S 1 1 002200 1 0 0 000000 0 0 0 000000 0 1 0 0 0 0
A 1 002200 0 1
S 0 0 000000 0 1 1 002300 1 0 0 000000 0 1 0 0 0 0
A 2 002300 1 0
S 0 0 000000 0 1 1 002400 0 2 0 000000 0 1 0 0 0 0
A 2 002400 0 2
S 0 0 000000 0 0 0 000000 0 0 0 000000 0 1 1 0 0 0
M 2 0
M 4 3
C 2 4

// ==== traceLogger.f ====
src/logCfgPkg.sv
src/traceFmtPkg.sv
src/eventCapture.sv
src/traceFifo.sv
src/traceEmitter.sv
src/traceLogger.sv
dv/traceLoggerTb.sv

// ==== Makefile ====
TOP = traceLoggerTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 -Mdir obj_dir --top-module $(TOP) -f traceLogger.f

# the log decides pass or fail, the simulator status alone is not trusted
run: compile
	./obj_dir/V$(TOP) 2>&1 | tee run.log
	grep -q "TEST RESULT: PASS" run.log

clean:
	rm -rf obj_dir run.log
